/* sim/hybrid_mem_testdata.txt */
# step port(S/C) lane op(R/W) addr(hex, flat for S, row for C) wdata(hex) be(hex) kind expect
# kind D: read data expected, E: error pulse expected, -: no response; expect is hex
1  S 0 W 040 11111111 f - 00000000
2  S 1 W 041 22222222 f - 00000000
3  S 2 W 042 33333333 f - 00000000
4  S 3 W 043 44444444 f - 00000000
5  S 0 W 004 a0a0a0a0 f - 00000000
6  S 1 W 005 b1b1b1b1 f - 00000000
7  S 0 R 040 00000000 0 D 11111111
8  S 1 R 041 00000000 0 D 22222222
9  S 2 R 042 00000000 0 D 33333333
10 S 3 R 043 00000000 0 D 44444444
11 S 2 W 046 deadbeef f - 00000000
12 S 2 W 046 00cafe00 6 - 00000000
13 S 2 R 046 00000000 0 D decafeef
14 C 3 W 011 12345678 f - 00000000
15 C 3 W 011 abcdef00 8 - 00000000
16 C 3 R 011 00000000 0 D ab345678
17 S 3 R 047 00000000 0 D ab345678
18 C 0 R 010 00000000 0 D 11111111
18 C 1 R 010 00000000 0 D 22222222
18 C 2 R 010 00000000 0 D 33333333
18 C 3 R 010 00000000 0 D 44444444
19 C 2 R 011 00000000 0 D decafeef
20 C 1 W 020 5a5a5a5a f - 00000000
21 C 1 R 020 00000000 0 D 5a5a5a5a
22 C 1 R 010 00000000 0 D 22222222
23 C 0 R 001 00000000 0 E 00000000
24 C 1 W 001 ffffffff f E 00000000
25 C 2 W 00f 77777777 f E 00000000
26 S 1 R 005 00000000 0 D b1b1b1b1
27 S 2 R 03e 00000000 0 D 00000000
28 S 0 R 004 00000000 0 D a0a0a0a0
29 S 2 R 042 00000000 0 D 33333333
29 C 2 R 011 00000000 0 D decafeef
29 C 0 R 010 00000000 0 D 11111111
30 S 1 W 045 0badf00d f - 00000000
30 C 1 W 012 600dcafe f - 00000000
31 S 1 R 045 00000000 0 D 0badf00d
31 C 1 R 012 00000000 0 D 600dcafe
32 S 3 W 043 44440000 3 - 00000000
32 C 3 R 002 00000000 0 E 00000000
33 S 3 R 043 00000000 0 D 44440000
34 C 3 R 010 00000000 0 D 44440000

/* hybrid_mem.f */
source/hybrid_mem_pkg.sv
source/sram_bank.sv
source/bank_port_arbiter.sv
source/resp_delay_line.sv
source/hybrid_mem_top.sv
sim/hybrid_mem_checker.sv
sim/hybrid_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The log is searched for the fail message to decide the result.

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module hybrid_mem_tb -Mdir obj_dir -f hybrid_mem.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vhybrid_mem_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

exit 0

/* sim/hybrid_mem_tb.sv */
/*
 * Testbench for hybrid_mem_top, run from the project root.
 * Lines of the data file that share a step number are issued in one cycle.
 * The data file assumes 16 reserved scratchpad rows per bank.
 */
`timescale 1ns/1ps

module hybrid_mem_tb;

  localparam int unsigned NumBanks  = hybrid_mem_pkg::DEF_NUM_BANKS;
  localparam int unsigned NumWords  = hybrid_mem_pkg::DEF_NUM_WORDS;
  localparam int unsigned DataWidth = hybrid_mem_pkg::DEF_DATA_WIDTH;
  localparam int unsigned Latency   = hybrid_mem_pkg::DEF_LATENCY;
  localparam int unsigned RowW      = $clog2(NumWords);
  localparam int unsigned SpmAddrW  = $clog2(NumBanks) + RowW;
  localparam int unsigned BeW       = DataWidth / hybrid_mem_pkg::BYTE_WIDTH;
  localparam int unsigned MaxWait   = 50;
  localparam logic [RowW:0] SpmRows = (RowW+1)'(16);

  typedef struct packed {
    int                   step;
    logic [7:0]           port;
    int                   lane;
    logic [7:0]           op;
    logic [31:0]          addr;
    logic [DataWidth-1:0] data;
    logic [BeW-1:0]       be;
    logic [7:0]           kind;
    logic [DataWidth-1:0] expd;
  } op_t;

  logic                               clk = 1'b0;
  logic                               rst_n;
  logic [RowW:0]                      spm_size;
  logic                               spm_req;
  logic                               spm_we;
  logic [SpmAddrW-1:0]                spm_addr;
  logic [DataWidth-1:0]               spm_wdata;
  logic [BeW-1:0]                     spm_be;
  logic [DataWidth-1:0]               spm_rdata;
  logic [NumBanks-1:0]                cache_valid;
  logic [NumBanks-1:0]                cache_ready;
  logic [NumBanks-1:0]                cache_we;
  logic [NumBanks-1:0][RowW-1:0]      cache_addr;
  logic [NumBanks-1:0][DataWidth-1:0] cache_wdata;
  logic [NumBanks-1:0][BeW-1:0]       cache_be;
  logic [NumBanks-1:0]                cache_rvalid;
  logic [NumBanks-1:0][DataWidth-1:0] cache_rdata;
  logic [NumBanks-1:0]                cache_err;

  int unsigned cycle       = 0;
  int unsigned timeouts    = 0;
  int unsigned file_errors = 0;
  op_t         ops[$];

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  hybrid_mem_top #(
    .NumBanks  (NumBanks),
    .NumWords  (NumWords),
    .DataWidth (DataWidth),
    .Latency   (Latency)
  ) i_hybrid_mem_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .spm_size_i     (spm_size),
    .spm_req_i      (spm_req),
    .spm_we_i       (spm_we),
    .spm_addr_i     (spm_addr),
    .spm_wdata_i    (spm_wdata),
    .spm_be_i       (spm_be),
    .spm_rdata_o    (spm_rdata),
    .cache_valid_i  (cache_valid),
    .cache_ready_o  (cache_ready),
    .cache_we_i     (cache_we),
    .cache_addr_i   (cache_addr),
    .cache_wdata_i  (cache_wdata),
    .cache_be_i     (cache_be),
    .cache_rvalid_o (cache_rvalid),
    .cache_rdata_o  (cache_rdata),
    .cache_err_o    (cache_err)
  );

  hybrid_mem_checker #(
    .NumBanks  (NumBanks),
    .NumWords  (NumWords),
    .DataWidth (DataWidth)
  ) i_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cycle_i        (cycle),
    .spm_req_i      (spm_req),
    .spm_addr_i     (spm_addr),
    .spm_rdata_i    (spm_rdata),
    .cache_ready_i  (cache_ready),
    .cache_rvalid_i (cache_rvalid),
    .cache_rdata_i  (cache_rdata),
    .cache_err_i    (cache_err)
  );

  task automatic load_ops();
    int                   fd;
    int                   n;
    string                line;
    op_t                  op;
    int                   step;
    logic [7:0]           port_c;
    int                   lane;
    logic [7:0]           op_c;
    logic [31:0]          addr;
    logic [DataWidth-1:0] data;
    logic [BeW-1:0]       be;
    logic [7:0]           kind_c;
    logic [DataWidth-1:0] expd;
    fd = $fopen("sim/hybrid_mem_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sim/hybrid_mem_testdata.txt");
      file_errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%d %s %d %s %h %h %h %s %h",
                      step, port_c, lane, op_c, addr, data, be, kind_c, expd);
          if (n == 9) begin
            op.step = step;
            op.port = port_c;
            op.lane = lane;
            op.op   = op_c;
            op.addr = addr;
            op.data = data;
            op.be   = be;
            op.kind = kind_c;
            op.expd = expd;
            ops.push_back(op);
          end else begin
            $display("Malformed line in data file: %s", line);
            file_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Issues one step and holds each cache lane until it is accepted
  task automatic run_step(input int first, input int last);
    logic [NumBanks-1:0]  pend;
    logic [7:0]           lane_kind [NumBanks];
    logic [DataWidth-1:0] lane_expd [NumBanks];
    logic                 spm_read;
    logic [DataWidth-1:0] spm_expd;
    int unsigned          waited;
    int                   l;
    pend     = '0;
    spm_read = 1'b0;
    spm_expd = '0;
    waited   = 0;
    for (int i = first; i <= last; i++) begin
      if (ops[i].port == "S") begin
        spm_req   = 1'b1;
        spm_we    = (ops[i].op == "W");
        spm_addr  = ops[i].addr[SpmAddrW-1:0];
        spm_wdata = ops[i].data;
        spm_be    = ops[i].be;
        spm_read  = (ops[i].op == "R");
        spm_expd  = ops[i].expd;
      end else begin
        l              = ops[i].lane;
        cache_valid[l] = 1'b1;
        cache_we[l]    = (ops[i].op == "W");
        cache_addr[l]  = ops[i].addr[RowW-1:0];
        cache_wdata[l] = ops[i].data;
        cache_be[l]    = ops[i].be;
        pend[l]        = 1'b1;
        lane_kind[l]   = ops[i].kind;
        lane_expd[l]   = ops[i].expd;
      end
    end
    do begin
      @(posedge clk);
      if (waited == 0 && spm_read) begin
        i_checker.expect_spm(cycle + Latency, spm_expd);
      end
      for (int b = 0; b < NumBanks; b++) begin
        if (pend[b] && cache_ready[b]) begin
          if (lane_kind[b] != "-") begin
            i_checker.expect_cache(b, cycle + Latency, lane_kind[b] == "E", lane_expd[b]);
          end
          pend[b] = 1'b0;
        end
      end
      #2;
      spm_req     = 1'b0;
      cache_valid = cache_valid & pend;
      waited++;
    end while (pend != '0 && waited < MaxWait);
    if (pend != '0) begin
      $display("Timeout: cache lanes %b not accepted within %0d cycles", pend, MaxWait);
      timeouts++;
      cache_valid = '0;
    end
  endtask

  initial begin
    int          first;
    int          last;
    int unsigned drain;
    rst_n       = 1'b0;
    spm_size    = SpmRows;
    spm_req     = 1'b0;
    spm_we      = 1'b0;
    spm_addr    = '0;
    spm_wdata   = '0;
    spm_be      = '0;
    // Cache requests during reset must not produce responses
    cache_valid = '1;
    cache_we    = '0;
    cache_addr  = '0;
    cache_wdata = '0;
    cache_be    = '0;
    // Odd lanes read above the reserved rows
    for (int b = 1; b < NumBanks; b += 2) begin
      cache_addr[b] = SpmRows[RowW-1:0];
    end
    load_ops();
    repeat (8) @(posedge clk);
    #2;
    rst_n       = 1'b1;
    cache_valid = '0;
    cache_addr  = '0;
    first = 0;
    while (first < ops.size()) begin
      last = first;
      while (last + 1 < ops.size() && ops[last+1].step == ops[first].step) begin
        last++;
      end
      run_step(first, last);
      first = last + 1;
    end
    // Let the last responses come back
    drain = 0;
    while (i_checker.pending() != 0 && drain < 20) begin
      @(negedge clk);
      drain++;
    end
    if (i_checker.pending() != 0) begin
      $display("Timeout: %0d expected responses never arrived", i_checker.pending());
      timeouts++;
    end
    $display("Errors: %0d check, %0d timeout, %0d data file",
             i_checker.err_count, timeouts, file_errors);
    if (i_checker.err_count == 0 && timeouts == 0 && file_errors == 0 && ops.size() > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* sim/hybrid_mem_checker.sv */
/*
 * Response checker for hybrid_mem_top. Expected responses come in through
 * expect_spm and expect_cache, each tagged with the cycle in which it is due.
 */
`timescale 1ns/1ps

module hybrid_mem_checker #(
  parameter int unsigned NumBanks  = hybrid_mem_pkg::DEF_NUM_BANKS,
  parameter int unsigned NumWords  = hybrid_mem_pkg::DEF_NUM_WORDS,
  parameter int unsigned DataWidth = hybrid_mem_pkg::DEF_DATA_WIDTH
) (
  input logic                                          clk_i,
  input logic                                          rst_n_i,
  input int unsigned                                   cycle_i,
  input logic                                          spm_req_i,
  input logic [$clog2(NumBanks)+$clog2(NumWords)-1:0]  spm_addr_i,
  input logic [DataWidth-1:0]                          spm_rdata_i,
  input logic [NumBanks-1:0]                           cache_ready_i,
  input logic [NumBanks-1:0]                           cache_rvalid_i,
  input logic [NumBanks-1:0][DataWidth-1:0]            cache_rdata_i,
  input logic [NumBanks-1:0]                           cache_err_i
);

  typedef struct packed {
    int unsigned          due;
    logic [DataWidth-1:0] data;
  } spm_exp_t;

  typedef struct packed {
    int unsigned          due;
    int unsigned          lane;
    logic                 err;
    logic [DataWidth-1:0] data;
  } cache_exp_t;

  spm_exp_t    spm_q[$];
  cache_exp_t  cache_q[$];
  int unsigned err_count = 0;

  task automatic expect_spm(input int unsigned due, input logic [DataWidth-1:0] data);
    spm_exp_t e;
    e.due  = due;
    e.data = data;
    spm_q.push_back(e);
  endtask

  task automatic expect_cache(input int unsigned lane, input int unsigned due,
                              input logic err, input logic [DataWidth-1:0] data);
    cache_exp_t e;
    e.due  = due;
    e.lane = lane;
    e.err  = err;
    e.data = data;
    cache_q.push_back(e);
  endtask

  function automatic int unsigned pending();
    return spm_q.size() + cache_q.size();
  endfunction

  // Scratchpad data is due on exactly one cycle and reads zero otherwise
  always @(posedge clk_i) begin
    logic [DataWidth-1:0] exp_data;
    exp_data = '0;
    if (rst_n_i) begin
      if (spm_q.size() > 0 && spm_q[0].due == cycle_i) begin
        exp_data = spm_q[0].data;
        spm_q.delete(0);
      end
      if (spm_rdata_i !== exp_data) begin
        $display("FAIL spm_rdata_o cycle %0d expected 0x%h got 0x%h",
                 cycle_i, exp_data, spm_rdata_i);
        err_count++;
      end
    end
  end

  // Ready drops only on the lane whose bank the scratchpad takes
  always @(posedge clk_i) begin
    logic [NumBanks-1:0] exp_ready;
    int unsigned         bank;
    if (!rst_n_i) begin
      // Delay lines are still unknown before the first reset edge
      if (cycle_i != 0 && (cache_rvalid_i !== '0 || cache_err_i !== '0)) begin
        $display("FAIL cache_rvalid_o/cache_err_o in reset expected 0x0 got 0x%h/0x%h",
                 cache_rvalid_i, cache_err_i);
        err_count++;
      end
    end else begin
      bank      = spm_addr_i % NumBanks;
      exp_ready = '1;
      if (spm_req_i) begin
        exp_ready[bank] = 1'b0;
      end
      if (cache_ready_i !== exp_ready) begin
        $display("FAIL cache_ready_o cycle %0d expected 0x%h got 0x%h",
                 cycle_i, exp_ready, cache_ready_i);
        err_count++;
      end
    end
  end

  // Pulses are matched per lane in acceptance order
  always @(posedge clk_i) begin
    int idx;
    if (rst_n_i) begin
      for (int b = 0; b < NumBanks; b++) begin
        if (cache_rvalid_i[b] || cache_err_i[b]) begin
          idx = -1;
          for (int i = 0; i < cache_q.size() && idx < 0; i++) begin
            if (cache_q[i].lane == b) begin
              idx = i;
            end
          end
          if (idx < 0) begin
            $display("Unexpected response pulse on cache lane %0d at cycle %0d", b, cycle_i);
            err_count++;
          end else begin
            if (cache_q[idx].due != cycle_i) begin
              $display("Cache lane %0d answered at cycle %0d instead of cycle %0d",
                       b, cycle_i, cache_q[idx].due);
              err_count++;
            end
            if (cache_rvalid_i[b] !== !cache_q[idx].err) begin
              $display("FAIL cache_rvalid_o[%0d] expected 0x%h got 0x%h",
                       b, !cache_q[idx].err, cache_rvalid_i[b]);
              err_count++;
            end
            if (cache_err_i[b] !== cache_q[idx].err) begin
              $display("FAIL cache_err_o[%0d] expected 0x%h got 0x%h",
                       b, cache_q[idx].err, cache_err_i[b]);
              err_count++;
            end
            if (!cache_q[idx].err && cache_rdata_i[b] !== cache_q[idx].data) begin
              $display("FAIL cache_rdata_o[%0d] expected 0x%h got 0x%h",
                       b, cache_q[idx].data, cache_rdata_i[b]);
              err_count++;
            end
            cache_q.delete(idx);
          end
        end
      end
      for (int i = cache_q.size() - 1; i >= 0; i--) begin
        if (cache_q[i].due <= cycle_i) begin
          $display("Missing response on cache lane %0d, due at cycle %0d",
                   cache_q[i].lane, cache_q[i].due);
          err_count++;
          cache_q.delete(i);
        end
      end
    end
  end

endmodule

/* source/hybrid_mem_top.sv */
/*
 * Banked SRAM shared by a fixed-latency scratchpad port and per-bank cache lanes.
 * NumBanks must be a power of two and at least 2; NumWords is rows per bank.
 * spm_size_i reserves the lowest rows of every bank and must stay stable
 * while any request is in flight.
 */
`timescale 1ns/1ps

module hybrid_mem_top #(
  parameter  int unsigned NumBanks  = hybrid_mem_pkg::DEF_NUM_BANKS,
  parameter  int unsigned NumWords  = hybrid_mem_pkg::DEF_NUM_WORDS,
  parameter  int unsigned DataWidth = hybrid_mem_pkg::DEF_DATA_WIDTH,
  parameter  int unsigned Latency   = hybrid_mem_pkg::DEF_LATENCY,
  localparam int unsigned BankSelW  = $clog2(NumBanks),
  localparam int unsigned RowW      = $clog2(NumWords),
  localparam int unsigned SpmAddrW  = BankSelW + RowW,
  localparam int unsigned BeW       = DataWidth / hybrid_mem_pkg::BYTE_WIDTH
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Reserved rows per bank, one extra bit so a whole bank can be reserved
  input  logic [RowW:0]                       spm_size_i,
  // Scratchpad port, flat word address
  input  logic                                spm_req_i,
  input  logic                                spm_we_i,
  input  logic [SpmAddrW-1:0]                 spm_addr_i,
  input  logic [DataWidth-1:0]                spm_wdata_i,
  input  logic [BeW-1:0]                      spm_be_i,
  output logic [DataWidth-1:0]                spm_rdata_o,
  // Cache lanes, one per bank, bank-local row address
  input  logic [NumBanks-1:0]                 cache_valid_i,
  output logic [NumBanks-1:0]                 cache_ready_o,
  input  logic [NumBanks-1:0]                 cache_we_i,
  input  logic [NumBanks-1:0][RowW-1:0]       cache_addr_i,
  input  logic [NumBanks-1:0][DataWidth-1:0]  cache_wdata_i,
  input  logic [NumBanks-1:0][BeW-1:0]        cache_be_i,
  output logic [NumBanks-1:0]                 cache_rvalid_o,
  output logic [NumBanks-1:0][DataWidth-1:0]  cache_rdata_o,
  output logic [NumBanks-1:0]                 cache_err_o
);

  typedef logic [BankSelW-1:0] bank_sel_t;

  // Routing for a scratchpad read response
  typedef struct packed {
    logic      valid;
    bank_sel_t bank;
  } spm_resp_t;

  typedef hybrid_mem_pkg::resp_kind_e [NumBanks-1:0] cache_kind_t;

  bank_sel_t                             spm_bank;
  logic [RowW-1:0]                       spm_row;
  logic [NumBanks-1:0]                   spm_bank_req;

  logic [NumBanks-1:0]                   cache_illegal;
  logic [NumBanks-1:0]                   cache_legal;

  logic [NumBanks-1:0]                   bank_en;
  hybrid_mem_pkg::port_sel_e [NumBanks-1:0] bank_sel;
  logic [NumBanks-1:0][DataWidth-1:0]    bank_rdata;

  spm_resp_t                             spm_resp_d;
  spm_resp_t                             spm_resp_q;
  cache_kind_t                           cache_kind_d;
  cache_kind_t                           cache_kind_q;

  // Low address bits pick the bank, the rest is the row
  assign spm_bank = spm_addr_i[BankSelW-1:0];
  assign spm_row  = spm_addr_i[SpmAddrW-1:BankSelW];

  always_comb begin
    spm_bank_req           = '0;
    spm_bank_req[spm_bank] = spm_req_i;
  end

  // Cache rows inside the scratchpad region never reach the SRAM
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      cache_illegal[b] = cache_valid_i[b] && ({1'b0, cache_addr_i[b]} < spm_size_i);
      cache_legal[b]   = cache_valid_i[b] && !cache_illegal[b];
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    logic                 mux_we;
    logic [RowW-1:0]      mux_addr;
    logic [DataWidth-1:0] mux_wdata;
    logic [BeW-1:0]       mux_be;

    bank_port_arbiter i_arbiter (
      .spm_req_i     (spm_bank_req[b]),
      .cache_req_i   (cache_legal[b]),
      .bank_en_o     (bank_en[b]),
      .cache_ready_o (cache_ready_o[b]),
      .sel_o         (bank_sel[b])
    );

    // Steer the winning port onto the bank
    always_comb begin
      if (bank_sel[b] == hybrid_mem_pkg::PORT_SPM) begin
        mux_we    = spm_we_i;
        mux_addr  = spm_row;
        mux_wdata = spm_wdata_i;
        mux_be    = spm_be_i;
      end else begin
        mux_we    = cache_we_i[b];
        mux_addr  = cache_addr_i[b];
        mux_wdata = cache_wdata_i[b];
        mux_be    = cache_be_i[b];
      end
    end

    sram_bank #(
      .NumWords  (NumWords),
      .DataWidth (DataWidth),
      .Latency   (Latency)
    ) i_sram_bank (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (bank_en[b]),
      .we_i    (mux_we),
      .addr_i  (mux_addr),
      .wdata_i (mux_wdata),
      .be_i    (mux_be),
      .rdata_o (bank_rdata[b])
    );
  end

  // Scratchpad writes need no response
  assign spm_resp_d.valid = spm_req_i && !spm_we_i;
  assign spm_resp_d.bank  = spm_bank;

  // Response kind decided at the handshake
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      cache_kind_d[b] = hybrid_mem_pkg::RESP_NONE;
      if (cache_valid_i[b] && cache_ready_o[b]) begin
        if (cache_illegal[b]) begin
          cache_kind_d[b] = hybrid_mem_pkg::RESP_ERR;
        end else if (!cache_we_i[b]) begin
          cache_kind_d[b] = hybrid_mem_pkg::RESP_DATA;
        end
      end
    end
  end

  resp_delay_line #(
    .dtype (spm_resp_t),
    .Depth (Latency)
  ) i_spm_resp_delay (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .d_i     (spm_resp_d),
    .q_o     (spm_resp_q)
  );

  resp_delay_line #(
    .dtype (cache_kind_t),
    .Depth (Latency)
  ) i_cache_resp_delay (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .d_i     (cache_kind_d),
    .q_o     (cache_kind_q)
  );

  // Scratchpad read data only while a response is due
  assign spm_rdata_o = spm_resp_q.valid ? bank_rdata[spm_resp_q.bank] : '0;

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      cache_rvalid_o[b] = (cache_kind_q[b] == hybrid_mem_pkg::RESP_DATA);
      cache_err_o[b]    = (cache_kind_q[b] == hybrid_mem_pkg::RESP_ERR);
      cache_rdata_o[b]  = cache_rvalid_o[b] ? bank_rdata[b] : '0;
    end
  end

endmodule

/* source/resp_delay_line.sv */
/*
 * Register chain of Depth stages for any packed payload type.
 * Depth must be at least 1. All stages clear to zero on reset.
 */
`timescale 1ns/1ps

module resp_delay_line #(
  parameter type         dtype = logic,
  parameter int unsigned Depth = 32'd1
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  dtype d_i,
  output dtype q_o
);

  localparam int unsigned Width = $bits(dtype);

  logic [Depth-1:0][Width-1:0] stage_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int s = 1; s < Depth; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  // Last stage back to the payload type
  assign q_o = dtype'(stage_q[Depth-1]);

endmodule

/* source/bank_port_arbiter.sv */
/*
 * Fixed-priority arbiter for one bank.
 * The scratchpad always wins; the cache is stalled through its ready signal.
 * Purely combinational, so a grant takes effect in the request cycle.
 */
`timescale 1ns/1ps

module bank_port_arbiter (
  input  logic                      spm_req_i,
  // Cache request already cleared of accesses into the scratchpad rows
  input  logic                      cache_req_i,
  output logic                      bank_en_o,
  output logic                      cache_ready_o,
  output hybrid_mem_pkg::port_sel_e sel_o
);

  always_comb begin
    bank_en_o     = 1'b0;
    cache_ready_o = 1'b1;
    sel_o         = hybrid_mem_pkg::PORT_CACHE;

    if (spm_req_i) begin
      // Scratchpad has a fixed latency to keep, the cache can wait
      bank_en_o     = 1'b1;
      cache_ready_o = 1'b0;
      sel_o         = hybrid_mem_pkg::PORT_SPM;
    end else if (cache_req_i) begin
      bank_en_o     = 1'b1;
      sel_o         = hybrid_mem_pkg::PORT_CACHE;
    end
  end

endmodule

/* source/sram_bank.sv */
/*
 * Single-port SRAM bank with per-byte write enables.
 * Read data appears on rdata_o exactly Latency cycles after the request.
 * Contents start at zero in simulation only.
 */
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned NumWords  = 32'd256,
  parameter int unsigned DataWidth = 32'd32,
  parameter int unsigned Latency   = 32'd1
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic                                              req_i,
  input  logic                                              we_i,
  input  logic [$clog2(NumWords)-1:0]                       addr_i,
  input  logic [DataWidth-1:0]                              wdata_i,
  input  logic [DataWidth/hybrid_mem_pkg::BYTE_WIDTH-1:0]   be_i,
  output logic [DataWidth-1:0]                              rdata_o
);

  localparam int unsigned ByteWidth = hybrid_mem_pkg::BYTE_WIDTH;
  localparam int unsigned NumBytes  = DataWidth / ByteWidth;

  logic [DataWidth-1:0]              mem_q [NumWords];
  logic [Latency-1:0][DataWidth-1:0] rdata_pipe_q;

  initial begin
    for (int i = 0; i < NumWords; i++) begin
      mem_q[i] = '0;
    end
  end

  // Byte-masked write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // First stage captures the array, later stages only add delay
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_pipe_q <= '0;
    end else begin
      if (req_i && !we_i) begin
        rdata_pipe_q[0] <= mem_q[addr_i];
      end
      for (int s = 1; s < Latency; s++) begin
        rdata_pipe_q[s] <= rdata_pipe_q[s-1];
      end
    end
  end

  assign rdata_o = rdata_pipe_q[Latency-1];

endmodule

/* source/hybrid_mem_pkg.sv */
/*
 * Shared enums and default sizes for the hybrid scratchpad/cache memory.
 * Bytes are 8 bits wide, so DataWidth must be a multiple of 8.
 */
package hybrid_mem_pkg;

  // Winner of one bank's arbitration
  typedef enum logic {
    PORT_CACHE = 1'b0,
    PORT_SPM   = 1'b1
  } port_sel_e;

  // Response due on a cache lane once the SRAM latency has elapsed
  typedef enum logic [1:0] {
    RESP_NONE = 2'd0,
    RESP_DATA = 2'd1,
    RESP_ERR  = 2'd2
  } resp_kind_e;

  // Default top-level sizes
  localparam int unsigned DEF_NUM_BANKS  = 32'd4;
  // Rows per bank
  localparam int unsigned DEF_NUM_WORDS  = 32'd256;
  localparam int unsigned DEF_DATA_WIDTH = 32'd32;
  // Read latency in cycles, at least 1
  localparam int unsigned DEF_LATENCY    = 32'd1;

  // Width of one byte lane in every data word
  localparam int unsigned BYTE_WIDTH     = 32'd8;

endpackage
